// ==== verilog/abj_pkg.sv ====
// decode stage shared definitions
`default_nettype none

package abj_pkg;

    // datapath and pc width
    localparam int xlen = 32;
    // instruction word width
    localparam int ilen = 32;
    // register index width
    localparam int reg_addr_w = 5;

    // major opcodes handled by decode
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jump   = 7'b1100111;

    // funct3 values that make op_load a real memory load
    localparam logic [2:0] f3_lb = 3'b000;
    localparam logic [2:0] f3_lw = 3'b010;
    localparam logic [2:0] f3_lh = 3'b011;
    // byte store shares the load byte encoding
    localparam logic [2:0] f3_sb = 3'b000;

    // alu operation class, refined later by funct fields
    typedef enum logic [1:0] {
        alu_add     = 2'd0,
        alu_sub_cmp = 2'd1,
        alu_funct   = 2'd2,
        alu_jump    = 2'd3
    } alu_op_t;

    // control bundle, msb first
    typedef struct packed {
        logic    mem_to_reg;
        logic    d_cache_access;
        // 1 read, 0 write
        logic    d_cache_op;
        logic    branch;
        logic    reg_write;
        alu_op_t alu_op;
        logic    alu_src;
        logic    is_imm;
        logic    is_byte_op;
        logic    illegal;
    } ctrl_t;

    // fetched word plus its pc
    typedef struct packed {
        logic [ilen-1:0] instr;
        logic [xlen-1:0] pc;
    } fetch_t;

    // packet handed to execute
    typedef struct packed {
        ctrl_t                 ctrl;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [xlen-1:0]       pc;
    } decode_t;

endpackage

`default_nettype wire

// ==== verilog/pipe_reg.sv ====
// one-slot valid/ready pipeline register
`timescale 1ns/1ps
`default_nettype none

module pipe_reg
#(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // accept when empty or when the held item leaves this edge
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_q <= 1'b0;
        else if (in_ready)
            valid_q <= in_valid;
    end

    // payload only moves on a real transfer
    always_ff @(posedge clk)
    begin
        if (in_ready && in_valid)
            data_q <= in_data;
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    // stalled item must not change or vanish
    hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("pipe_reg output changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/control_unit.sv ====
// opcode and funct3 control decode
`timescale 1ns/1ps
`default_nettype none

module control_unit
(
    input  logic [6:0]     opcode,
    input  logic [2:0]     funct3,
    output abj_pkg::ctrl_t ctrl
);
    import abj_pkg::*;

    always_comb
    begin
        // start from all-zero so each class only sets what it needs
        ctrl = '0;
        ctrl.alu_op = alu_add;
        case (opcode)
            op_rtype:
            begin
                ctrl.reg_write = 1'b1;
                // funct3/funct7 pick the real operation in execute
                ctrl.alu_op = alu_funct;
            end
            op_load:
            begin
                if (funct3 == f3_lb || funct3 == f3_lw || funct3 == f3_lh)
                begin
                    // true load, address is rs1 + imm
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    ctrl.alu_src = 1'b1;
                    ctrl.d_cache_access = 1'b1;
                    ctrl.d_cache_op = 1'b1;
                    ctrl.is_byte_op = (funct3 == f3_lb);
                end
                else
                begin
                    // LI, immediate straight into rd
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    ctrl.is_imm = 1'b1;
                end
            end
            op_store:
            begin
                // address from rs1 + imm, data from rs2
                ctrl.alu_src = 1'b1;
                ctrl.d_cache_access = 1'b1;
                // write
                ctrl.d_cache_op = 1'b0;
                ctrl.is_byte_op = (funct3 == f3_sb);
            end
            op_branch:
            begin
                ctrl.branch = 1'b1;
                // compare rs1 against rs2
                ctrl.alu_op = alu_sub_cmp;
            end
            op_jump:
            begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_jump;
            end
            default:
            begin
                // unknown opcode, nothing but the flag
                ctrl.illegal = 1'b1;
            end
        endcase
    end

    // byte ops only exist as memory accesses
    always_comb
    begin
        byte_op_is_mem: assert (!ctrl.is_byte_op || ctrl.d_cache_access)
            else $error("is_byte_op without d_cache_access, opcode %b", opcode);
    end

endmodule

`default_nettype wire

// ==== verilog/imm_gen.sv ====
// immediate extraction and sign extension
`timescale 1ns/1ps
`default_nettype none

module imm_gen
(
    input  logic [abj_pkg::ilen-1:0] instr,
    output logic [abj_pkg::xlen-1:0] imm
);
    import abj_pkg::*;

    logic [6:0]      opcode;
    logic            sign;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;

    assign opcode = instr[6:0];
    // every format keeps its sign in bit 31
    assign sign = instr[31];

    // I format, imm[11:0] in the top bits
    assign imm_i = {{(xlen-12){sign}}, instr[31:20]};
    // S format, split around rd position
    assign imm_s = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
    // B format, halfword offset so bit 0 is always zero
    assign imm_b = {{(xlen-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb
    begin
        case (opcode)
            op_load, op_jump:
                imm = imm_i;
            op_store:
                imm = imm_s;
            op_branch:
                imm = imm_b;
            // R-type and unknown opcodes have no immediate
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/decode_merge.sv ====
// decode packet assembly and register field cleanup
`timescale 1ns/1ps
`default_nettype none

module decode_merge
(
    input  logic [abj_pkg::xlen-1:0] imm,
    input  abj_pkg::fetch_t          fetch,
    input  abj_pkg::ctrl_t           ctrl,
    output abj_pkg::decode_t         dec
);
    import abj_pkg::*;

    logic [reg_addr_w-1:0] rs1_raw;
    logic [reg_addr_w-1:0] rs2_raw;
    logic [reg_addr_w-1:0] rd_raw;
    logic                  rs1_used;
    logic                  rs2_used;

    // standard field positions
    assign rd_raw  = fetch.instr[11:7];
    assign rs1_raw = fetch.instr[19:15];
    assign rs2_raw = fetch.instr[24:20];

    // LI and illegal words read no source register
    assign rs1_used = !ctrl.is_imm && !ctrl.illegal;

    // rs2 only for R-type, store data, branch compare
    assign rs2_used = (ctrl.alu_op == alu_funct)
                   || (ctrl.d_cache_access && !ctrl.d_cache_op)
                   || (ctrl.alu_op == alu_sub_cmp);

    always_comb
    begin
        dec.ctrl   = ctrl;
        dec.imm    = imm;
        dec.pc     = fetch.pc;
        dec.funct3 = fetch.instr[14:12];
        dec.funct7 = fetch.instr[31:25];
        // zeroed indices keep the hazard unit from seeing false deps
        dec.rs1    = rs1_used ? rs1_raw : '0;
        dec.rs2    = rs2_used ? rs2_raw : '0;
        dec.rd     = ctrl.reg_write ? rd_raw : '0;
    end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
// instruction decode stage top
`timescale 1ns/1ps
`default_nettype none

module decode_stage
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  abj_pkg::fetch_t  in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output abj_pkg::decode_t out_data
);
    import abj_pkg::*;

    // registered fetch side
    fetch_t          fetch_q;
    logic            fetch_valid;
    logic            dec_ready;
    // combinational decode results
    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    decode_t         dec;

    // input slot, holds the raw word
    pipe_reg #(.payload_t(fetch_t)) fetch_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (fetch_valid),
        .out_ready (dec_ready),
        .out_data  (fetch_q)
    );

    // control and immediate work side by side on the held word
    control_unit u_control_unit (
        .opcode (fetch_q.instr[6:0]),
        .funct3 (fetch_q.instr[14:12]),
        .ctrl   (ctrl)
    );

    imm_gen u_imm_gen (
        .instr (fetch_q.instr),
        .imm   (imm)
    );

    decode_merge u_decode_merge (
        .imm   (imm),
        .fetch (fetch_q),
        .ctrl  (ctrl),
        .dec   (dec)
    );

    // output slot toward execute
    pipe_reg #(.payload_t(decode_t)) dec_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_ready  (dec_ready),
        .in_data   (dec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // four cycles of reset, let go on a falling edge
    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/decode_stage_tb.sv ====
// decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;
    import abj_pkg::*;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    fetch_t  in_data;
    logic    out_valid;
    logic    out_ready;
    decode_t out_data;

    // stimulus rows, expected immediate worked out by hand
    logic [31:0] row_instr[$];
    logic [31:0] row_pc[$];
    logic [31:0] row_imm[$];
    string       row_name[$];

    int          n_rows;
    int          n_out;
    int          n_pass;
    int          n_fail;
    int          total_fail;
    int          idx;
    bit          reset_bad;
    logic [31:0] lfsr;
    logic        bit_a;
    logic        bit_b;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_stage dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // instruction encoders, standard field layout
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        enc_r = {f7, rs2, rs1, f3, rd, op_rtype};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        enc_i = {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
        enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    // offset bit 0 is dropped by the format
    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic [31:0] pc,
                           input logic [31:0] imm, input string name);
        row_instr.push_back(instr);
        row_pc.push_back(pc);
        row_imm.push_back(imm);
        row_name.push_back(name);
    endtask

    // reference control bundle per opcode class
    function automatic ctrl_t expect_ctrl(input logic [31:0] instr);
        logic [6:0] op;
        logic [2:0] f3;
        ctrl_t      c;
        op = instr[6:0];
        f3 = instr[14:12];
        c = '0;
        if (op == op_rtype)
        begin
            c.reg_write = 1'b1;
            c.alu_op = alu_funct;
        end
        else if (op == op_load && (f3 == f3_lb || f3 == f3_lw || f3 == f3_lh))
        begin
            c.reg_write = 1'b1;
            c.mem_to_reg = 1'b1;
            c.alu_src = 1'b1;
            c.d_cache_access = 1'b1;
            c.d_cache_op = 1'b1;
            c.is_byte_op = (f3 == f3_lb);
        end
        else if (op == op_load)
        begin
            // LI
            c.reg_write = 1'b1;
            c.mem_to_reg = 1'b1;
            c.is_imm = 1'b1;
        end
        else if (op == op_store)
        begin
            c.alu_src = 1'b1;
            c.d_cache_access = 1'b1;
            c.is_byte_op = (f3 == 3'b000);
        end
        else if (op == op_branch || op == op_jump)
        begin
            c.branch = 1'b1;
            c.alu_op = (op == op_branch) ? alu_sub_cmp : alu_jump;
        end
        else
            c.illegal = 1'b1;
        return c;
    endfunction

    function automatic decode_t expect_decode(input logic [31:0] instr,
                                              input logic [31:0] pc, input logic [31:0] imm);
        decode_t d;
        logic    rs2_live;
        d.ctrl = expect_ctrl(instr);
        d.imm = imm;
        d.pc = pc;
        d.funct3 = instr[14:12];
        d.funct7 = instr[31:25];
        // rd only when written, rs1 not for LI or illegal
        d.rd = d.ctrl.reg_write ? instr[11:7] : 5'd0;
        d.rs1 = (d.ctrl.is_imm || d.ctrl.illegal) ? 5'd0 : instr[19:15];
        rs2_live = instr[6:0] == op_rtype || instr[6:0] == op_store
                || instr[6:0] == op_branch;
        d.rs2 = rs2_live ? instr[24:20] : 5'd0;
        return d;
    endfunction

    task automatic compare_field(input string test, input string field,
                                 input logic [31:0] exp, input logic [31:0] act, inout bit ok);
        if (act !== exp)
        begin
            $display("[FAIL] %s: %s exp %h got %h", test, field, exp, act);
            ok = 1'b0;
        end
    endtask

    task automatic check_output(input int k);
        decode_t exp;
        bit      ok;
        exp = expect_decode(row_instr[k], row_pc[k], row_imm[k]);
        ok = 1'b1;
        compare_field(row_name[k], "ctrl", 32'(exp.ctrl), 32'(out_data.ctrl), ok);
        compare_field(row_name[k], "imm", exp.imm, out_data.imm, ok);
        compare_field(row_name[k], "rs1", 32'(exp.rs1), 32'(out_data.rs1), ok);
        compare_field(row_name[k], "rs2", 32'(exp.rs2), 32'(out_data.rs2), ok);
        compare_field(row_name[k], "rd", 32'(exp.rd), 32'(out_data.rd), ok);
        compare_field(row_name[k], "funct3", 32'(exp.funct3), 32'(out_data.funct3), ok);
        compare_field(row_name[k], "funct7", 32'(exp.funct7), 32'(out_data.funct7), ok);
        // pc doubles as the order check
        compare_field(row_name[k], "pc", exp.pc, out_data.pc, ok);
        if (ok)
        begin
            $display("[PASS] %s", row_name[k]);
            n_pass++;
        end
        else
        begin
            $display("test %s had wrong fields", row_name[k]);
            n_fail++;
        end
    endtask

    // output monitor, values sampled before the edge updates them
    always @(posedge clk)
    begin
        if (rst_n && out_valid && out_ready)
        begin
            if (n_out >= n_rows)
            begin
                $display("an extra item came out after the last table row");
                n_fail++;
            end
            else
                check_output(n_out);
            n_out++;
        end
    end

    // random back-pressure, low when both bits are zero
    initial
    begin
        out_ready = 1'b0;
        lfsr = 32'heb01;
        forever
        begin
            @(negedge clk);
            lfsr = lfsr_next(lfsr);
            bit_a = lfsr[0];
            lfsr = lfsr_next(lfsr);
            bit_b = lfsr[0];
            out_ready = bit_a | bit_b;
        end
    end

    initial
    begin
        in_valid = 1'b0;
        in_data = '0;
        add_row(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1), 32'h0000_1000, 32'h0, "add");
        add_row(enc_r(7'h20, 5'd31, 5'd30, 3'b000, 5'd29), 32'h0000_1004, 32'h0, "sub");
        add_row(enc_i(op_load, f3_lb, 5'd5, 5'd6, 12'h7ff), 32'h0000_1008, 32'h7ff, "lb pos");
        add_row(enc_i(op_load, f3_lw, 5'd7, 5'd8, 12'h800), 32'h0000_100c, 32'hffff_f800,
                "lw neg");
        add_row(enc_i(op_load, f3_lh, 5'd9, 5'd10, 12'h004), 32'h0000_1010, 32'h4, "lh pos");
        add_row(enc_i(op_load, 3'b001, 5'd11, 5'd7, 12'hfff), 32'h0000_1014, 32'hffff_ffff,
                "li f3 001");
        add_row(enc_i(op_load, 3'b100, 5'd12, 5'd13, 12'h123), 32'h0000_1018, 32'h123,
                "li f3 100");
        add_row(enc_i(op_load, 3'b101, 5'd14, 5'd15, 12'h9ab), 32'h0000_101c, 32'hffff_f9ab,
                "li f3 101");
        add_row(enc_i(op_load, 3'b110, 5'd16, 5'd17, 12'h010), 32'h0000_1020, 32'h10,
                "li f3 110");
        add_row(enc_i(op_load, 3'b111, 5'd18, 5'd19, 12'h800), 32'h0000_1024, 32'hffff_f800,
                "li f3 111");
        add_row(enc_s(3'b000, 5'd9, 5'd8, 12'h07f), 32'h0000_1028, 32'h7f, "sb pos");
        add_row(enc_s(3'b010, 5'd20, 5'd21, 12'hf80), 32'h0000_102c, 32'hffff_ff80, "sw neg");
        add_row(enc_s(3'b001, 5'd22, 5'd23, 12'h555), 32'h0000_1030, 32'h555, "sh pos");
        add_row(enc_b(3'b000, 5'd1, 5'd2, 13'h0ffe), 32'h0000_1034, 32'hffe, "beq pos");
        add_row(enc_b(3'b001, 5'd3, 5'd4, 13'h1000), 32'h0000_1038, 32'hffff_f000, "bne neg");
        add_row(enc_b(3'b100, 5'd5, 5'd6, 13'h1ffe), 32'h0000_103c, 32'hffff_fffe, "blt neg");
        add_row(enc_i(op_jump, 3'b000, 5'd1, 5'd10, 12'h010), 32'h8000_0040, 32'h10,
                "jump pos");
        add_row(enc_i(op_jump, 3'b000, 5'd0, 5'd1, 12'hffc), 32'h8000_0044, 32'hffff_fffc,
                "jump neg");
        add_row(enc_i(7'b0010011, 3'b000, 5'd3, 5'd4, 12'h123), 32'h0000_1048, 32'h0,
                "illegal op-imm");
        add_row(32'hffff_ffff, 32'hffff_fffc, 32'h0, "illegal all ones");
        n_rows = row_instr.size();

        @(posedge rst_n);
        // both slots empty straight after reset
        if (out_valid !== 1'b0 || in_ready !== 1'b1)
        begin
            $display("[FAIL] reset: out_valid %h in_ready %h", out_valid, in_ready);
            reset_bad = 1'b1;
        end

        idx = 0;
        while (idx < n_rows)
        begin
            @(negedge clk);
            in_valid = 1'b1;
            in_data.instr = row_instr[idx];
            in_data.pc = row_pc[idx];
            @(posedge clk);
            if (in_ready)
                idx++;
        end
        @(negedge clk);
        in_valid = 1'b0;

        wait (n_out == n_rows);
        repeat (4) @(negedge clk);
        total_fail = n_fail + (reset_bad ? 1 : 0);
        $display("passed %0d failed %0d", n_pass, total_fail);
        if (total_fail == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // twenty cycles per row is far beyond any stall pattern
    initial
    begin
        @(posedge rst_n);
        repeat (n_rows * 20) @(posedge clk);
        $display("watchdog ran out with %0d of %0d rows out", n_out, n_rows);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/abj_pkg.sv
verilog/pipe_reg.sv
verilog/control_unit.sv
verilog/imm_gen.sv
verilog/decode_merge.sv
verilog/decode_stage.sv
verif/tb_clock.sv
verif/decode_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the decode stage simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module decode_stage_tb \
    -f build.f \
    -o decode_stage_sim

output=$(./obj_dir/decode_stage_sim)
echo "$output"

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi
